// File: design/sifhParamPkg.sv
package sifhParamPkg;

    // detector array
    localparam int pixelNum   = 4;
    localparam int pixelWidth = $clog2(pixelNum);

    // raw tdc timestamp
    localparam int stampWidth = 12;

    // histogram shape, bin is the top bits of the stamp
    localparam int binNum   = 16;
    localparam int binWidth = $clog2(binNum);

    // one histogram word, saturating
    localparam int countWidth = 8;

    // shared memory, pixel in upper address bits
    localparam int ramDepth     = pixelNum * binNum;
    localparam int ramAddrWidth = $clog2(ramDepth);

endpackage

// File: design/sifhTypesPkg.sv
package sifhTypesPkg;

    import sifhParamPkg::*;

    // top-level input word
    typedef struct packed {
        logic [pixelWidth-1:0] pixel;
        logic [stampWidth-1:0] stamp;
    } detection_t;

    // memory address, pixel major
    typedef struct packed {
        logic [pixelWidth-1:0] pixel;
        logic [binWidth-1:0]   bin;
    } binAddr_t;

    typedef struct packed {
        logic                  en;
        binAddr_t              addr;
        logic [countWidth-1:0] data;
    } ramWrite_t;

    // one word of a histogram scan
    typedef struct packed {
        logic                  valid;
        logic                  first; // bin 0 of a pixel
        logic                  last;  // last bin of a pixel
        binAddr_t              addr;
        logic [countWidth-1:0] count;
    } scanBeat_t;

    typedef struct packed {
        logic [pixelWidth-1:0] pixel;
        logic [binWidth-1:0]   bin;
        logic [countWidth-1:0] count;
    } peakReport_t;

    typedef enum logic [1:0] {
        stateClear,
        stateAccum,
        stateScan,
        stateDrain
    } histState_e;

endpackage

// File: design/tdcSampleLatch.sv
`timescale 1ns/10ps

module tdcSampleLatch (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     hitValid,
    input  sifhTypesPkg::detection_t hit,
    input  logic                     ready,
    output logic                     sampleValid,
    output sifhTypesPkg::binAddr_t   sampleAddr
);

    import sifhParamPkg::*;

    logic [binWidth-1:0] hitBin;

    // coarse time only, fine bits are dropped
    assign hitBin = hit.stamp[stampWidth-1 -: binWidth];

    // strobe is dropped while the engine is busy
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sampleValid <= 1'b0;
        end else begin
            sampleValid <= hitValid && ready;
        end
    end

    always_ff @(posedge clk) begin
        sampleAddr.pixel <= hit.pixel; // pixel selects the histogram
        sampleAddr.bin   <= hitBin;
    end

endmodule

// File: design/histControl.sv
`timescale 1ns/10ps

module histControl (
    input  logic                                clk,
    input  logic                                res,
    input  logic                                sampleValid,
    input  sifhTypesPkg::binAddr_t              sampleAddr,
    input  logic                                acqDone,
    output sifhTypesPkg::binAddr_t              ramRdAddr,
    input  logic [sifhParamPkg::countWidth-1:0] ramRdData,
    output sifhTypesPkg::ramWrite_t             ramWrite,
    output sifhTypesPkg::scanBeat_t             scanBeat,
    output logic                                ready
);

    import sifhParamPkg::*;
    import sifhTypesPkg::*;

    histState_e state;
    histState_e stateNext;

    logic [ramAddrWidth-1:0] addrCnt; // shared by clear and scan
    logic                    lastAddr;

    // read-modify-write pipeline
    logic                  accValid; // read data arrives this cycle
    binAddr_t              accAddr;
    logic                  fwdHit;
    logic [countWidth-1:0] fwdData;
    logic [countWidth-1:0] accBase;
    logic [countWidth-1:0] accSum;

    // scan pipeline, one beat behind the read
    logic     scanValid;
    binAddr_t scanAddr;

    assign lastAddr = (addrCnt == ramAddrWidth'(ramDepth - 1));

    always_comb begin
        stateNext = state;
        case (state)
            stateClear: begin
                if (lastAddr) begin
                    stateNext = stateAccum;
                end
            end
            stateAccum: begin
                if (acqDone) begin
                    stateNext = stateDrain;
                end
            end
            stateDrain: begin
                // wait until no hit is left in the pipeline
                if (!sampleValid && !accValid) begin
                    stateNext = stateScan;
                end
            end
            stateScan: begin
                if (lastAddr) begin
                    stateNext = stateAccum;
                end
            end
            default: stateNext = stateClear;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= stateClear;
            addrCnt   <= '0;
            accValid  <= 1'b0;
            fwdHit    <= 1'b0;
            scanValid <= 1'b0;
        end else begin
            state     <= stateNext;
            accValid  <= sampleValid;
            // read and write to one word in the same cycle returns stale data
            fwdHit    <= sampleValid && ramWrite.en && (sampleAddr == ramWrite.addr);
            scanValid <= (state == stateScan);
            if (state == stateClear || state == stateScan) begin
                addrCnt <= addrCnt + 1'b1; // wraps to 0 for the next pass
            end
        end
    end

    always_ff @(posedge clk) begin
        accAddr  <= sampleAddr;
        fwdData  <= ramWrite.data;
        scanAddr <= binAddr_t'(addrCnt);
    end

    assign accBase = fwdHit ? fwdData : ramRdData;
    assign accSum  = (accBase == '1) ? accBase : accBase + 1'b1; // saturate at max

    assign ramRdAddr = (state == stateScan) ? binAddr_t'(addrCnt) : sampleAddr;

    // only one source is active at a time
    always_comb begin
        ramWrite.en   = 1'b0;
        ramWrite.addr = accAddr;
        ramWrite.data = accSum;
        if (scanValid) begin
            ramWrite.en   = 1'b1; // zero the word just read out
            ramWrite.addr = scanAddr;
            ramWrite.data = '0;
        end else if (state == stateClear) begin
            ramWrite.en   = 1'b1;
            ramWrite.addr = binAddr_t'(addrCnt);
            ramWrite.data = '0;
        end else if (accValid) begin
            ramWrite.en = 1'b1;
        end
    end

    assign scanBeat.valid = scanValid;
    assign scanBeat.first = (scanAddr.bin == '0);
    assign scanBeat.last  = (scanAddr.bin == binWidth'(binNum - 1));
    assign scanBeat.addr  = scanAddr;
    assign scanBeat.count = ramRdData;

    assign ready = (state == stateAccum);

endmodule

// File: design/histRam.sv
`timescale 1ns/10ps

module histRam (
    input  logic                                clk,
    input  sifhTypesPkg::binAddr_t              ramRdAddr,
    output logic [sifhParamPkg::countWidth-1:0] ramRdData,
    input  sifhTypesPkg::ramWrite_t             ramWrite
);

    import sifhParamPkg::*;

    logic [countWidth-1:0] mem [ramDepth];

    // write port
    always_ff @(posedge clk) begin
        if (ramWrite.en) begin
            mem[ramWrite.addr] <= ramWrite.data;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        ramRdData <= mem[ramRdAddr];
    end

endmodule

// File: design/peakFinder.sv
`timescale 1ns/10ps

module peakFinder (
    input  logic                      clk,
    input  logic                      res,
    input  sifhTypesPkg::scanBeat_t   scanBeat,
    output logic                      peakValid,
    output sifhTypesPkg::peakReport_t peak
);

    import sifhParamPkg::*;

    // running maximum of the pixel being scanned
    logic [countWidth-1:0] maxCount;
    logic [binWidth-1:0]   maxBin;

    logic                  take;
    logic [countWidth-1:0] curCount;
    logic [binWidth-1:0]   curBin;

    // strictly greater only, so the lower bin keeps a tie
    assign take     = scanBeat.first || (scanBeat.count > maxCount);
    assign curCount = take ? scanBeat.count : maxCount;
    assign curBin   = take ? scanBeat.addr.bin : maxBin;

    always_ff @(posedge clk) begin
        if (scanBeat.valid) begin
            maxCount <= curCount;
            maxBin   <= curBin;
        end
    end

    // report includes the last beat itself
    always_ff @(posedge clk) begin
        if (scanBeat.valid && scanBeat.last) begin
            peak.pixel <= scanBeat.addr.pixel;
            peak.bin   <= curBin;
            peak.count <= curCount;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= scanBeat.valid && scanBeat.last; // one cycle per pixel
        end
    end

endmodule

// File: design/sifhHistTop.sv
`timescale 1ns/10ps

module sifhHistTop (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      hitValid,
    input  sifhTypesPkg::detection_t  hit,
    input  logic                      acqDone,
    output logic                      ready,
    output logic                      peakValid,
    output sifhTypesPkg::peakReport_t peak
);

    import sifhParamPkg::*;
    import sifhTypesPkg::*;

    logic                  sampleValid;
    binAddr_t              sampleAddr;
    binAddr_t              ramRdAddr;
    logic [countWidth-1:0] ramRdData;
    ramWrite_t             ramWrite;
    scanBeat_t             scanBeat;

    // detection in, memory address out
    tdcSampleLatch tdcSampleLatch_i (
        .clk         (clk),
        .res         (res),
        .hitValid    (hitValid),
        .hit         (hit),
        .ready       (ready),
        .sampleValid (sampleValid),
        .sampleAddr  (sampleAddr)
    );

    histControl histControl_i (
        .clk         (clk),
        .res         (res),
        .sampleValid (sampleValid),
        .sampleAddr  (sampleAddr),
        .acqDone     (acqDone),
        .ramRdAddr   (ramRdAddr),
        .ramRdData   (ramRdData),
        .ramWrite    (ramWrite),
        .scanBeat    (scanBeat),
        .ready       (ready)
    );

    // one memory for all pixels
    histRam histRam_i (
        .clk       (clk),
        .ramRdAddr (ramRdAddr),
        .ramRdData (ramRdData),
        .ramWrite  (ramWrite)
    );

    peakFinder peakFinder_i (
        .clk       (clk),
        .res       (res),
        .scanBeat  (scanBeat),
        .peakValid (peakValid),
        .peak      (peak)
    );

endmodule

// File: verif/sifhHistTb.sv
`timescale 1ns/10ps

module sifhHistTb;

    import sifhParamPkg::*;
    import sifhTypesPkg::*;

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 16;
    localparam int countMax    = (1 << countWidth) - 1;
    localparam int fineWidth   = stampWidth - binWidth;
    localparam logic [31:0] lfsrSeed = 32'heffa_6694;

    // wait limits in cycles
    localparam int readyLimit  = 2 * ramDepth + 32;
    localparam int reportLimit = ramDepth + 32;

    // hits offered per test, dropped ones included
    localparam int singleHits = 36;
    localparam int burstHits  = 60;
    localparam int satHits    = 305;
    localparam int tieHits    = 12;
    localparam int randomHits = 200;
    localparam int frameHits  = ramDepth + 20; // most are dropped during the scan
    localparam int hitTotal   = singleHits + burstHits + satHits + tieHits + randomHits + frameHits;
    localparam int scanCount  = 8;
    localparam int scanCycles = ramDepth + 16; // drain, scan and last report
    localparam int watchdogCycles =
        resetCycles + ramDepth + 2 * hitTotal + scanCount * scanCycles + 500;

    logic        clk;
    logic        res;
    logic        hitValid;
    detection_t  hit;
    logic        acqDone;
    logic        ready;
    logic        peakValid;
    peakReport_t peak;

    int          model [pixelNum][binNum]; // expected histogram
    peakReport_t reportQ [$];
    logic [31:0] lfsrState;
    int          errors;

    sifhHistTop sifhHistTop_i (
        .clk       (clk),
        .res       (res),
        .hitValid  (hitValid),
        .hit       (hit),
        .acqDone   (acqDone),
        .ready     (ready),
        .peakValid (peakValid),
        .peak      (peak)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    // reports are picked up mid-cycle
    always @(negedge clk) begin
        if (res && peakValid) begin
            reportQ.push_back(peak);
        end
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003; // taps 32 22 2 1
        end
        return next;
    endfunction

    // one lfsr step for every bit taken
    function automatic int takeBits(input int n);
        int value;
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            value     = (value << 1) | int'(lfsrState[0]);
            lfsrState = lfsrNext(lfsrState);
        end
        return value;
    endfunction

    // lowest bin wins a tie
    function automatic peakReport_t expectedPeak(input int pixel);
        peakReport_t best;
        int          bestCount;
        int          b;
        best.pixel = pixelWidth'(pixel);
        best.bin   = '0;
        bestCount  = model[pixel][0];
        for (b = 1; b < binNum; b++) begin
            if (model[pixel][b] > bestCount) begin
                bestCount = model[pixel][b];
                best.bin  = binWidth'(b);
            end
        end
        best.count = countWidth'(bestCount);
        return best;
    endfunction

    task automatic clearModel();
        int p;
        int b;
        for (p = 0; p < pixelNum; p++) begin
            for (b = 0; b < binNum; b++) begin
                model[p][b] = 0;
            end
        end
    endtask

    task automatic abortRun(input string why);
        errors++;
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compareReport(input string testName, input peakReport_t expected,
                                 input peakReport_t actual);
        if (actual !== expected) begin
            abortRun({$sformatf("** Error %s: expected pixel %0d bin %0d count %0d, ",
                                testName, expected.pixel, expected.bin, expected.count),
                      $sformatf("actual pixel %0d bin %0d count %0d",
                                actual.pixel, actual.bin, actual.count)});
        end
    endtask

    task automatic compareReady(input string testName, input logic expected,
                                input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("** Error %s: ready expected %0b, actual %0b",
                               testName, expected, actual));
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // taken tells whether the engine should accept this strobe
    task automatic sendHit(input string testName, input int pixel, input int bin,
                           input bit taken);
        compareReady(testName, taken, ready);
        hitValid  = 1'b1;
        hit.pixel = pixelWidth'(pixel);
        hit.stamp = {binWidth'(bin), fineWidth'(takeBits(fineWidth))}; // random fine bits
        if (taken && model[pixel][bin] < countMax) begin
            model[pixel][bin]++;
        end
        @(posedge clk);
        #1;
        hitValid = 1'b0;
    endtask

    task automatic hitBurst(input string testName, input int pixel, input int bin,
                            input int count, input int gap);
        int i;
        for (i = 0; i < count; i++) begin
            sendHit(testName, pixel, bin, 1'b1);
            idleCycles(gap);
        end
    endtask

    task automatic waitReady(input string testName);
        int waited;
        waited = 0;
        while (ready !== 1'b1) begin
            if (waited == readyLimit) begin
                abortRun($sformatf("%s: ready did not rise within %0d cycles",
                                   testName, readyLimit));
            end
            idleCycles(1);
            waited++;
        end
    endtask

    task automatic pulseAcqDone(input string testName);
        compareReady(testName, 1'b1, ready);
        acqDone = 1'b1;
        @(posedge clk);
        #1;
        acqDone = 1'b0;
        compareReady(testName, 1'b0, ready); // busy until the scan ends
    endtask

    // the scan leaves the memory cleared, so the model starts over
    task automatic collectReports(input string testName);
        int          waited;
        int          p;
        peakReport_t actual;
        waited = 0;
        while (reportQ.size() < pixelNum) begin
            if (waited == reportLimit) begin
                abortRun($sformatf("%s: only %0d of %0d peak reports arrived",
                                   testName, reportQ.size(), pixelNum));
            end
            idleCycles(1);
            waited++;
        end
        for (p = 0; p < pixelNum; p++) begin
            actual = reportQ.pop_front();
            compareReport(testName, expectedPeak(p), actual);
        end
        clearModel();
    endtask

    task automatic runScan(input string testName);
        pulseAcqDone(testName);
        collectReports(testName);
        waitReady(testName);
    endtask

    task automatic testClearAfterReset();
        string name;
        name = "testClearAfterReset";
        compareReady(name, 1'b0, ready); // clear still running
        waitReady(name);
        runScan(name);
    endtask

    task automatic testSingleHits();
        string name;
        int    p;
        name = "testSingleHits";
        for (p = 0; p < pixelNum; p++) begin
            hitBurst(name, p, p + 2, p + 1, 1);
            hitBurst(name, p, binNum - 1 - p, p + 3, 1);
            hitBurst(name, p, 7, 2, 1);
        end
        runScan(name);
    endtask

    task automatic testBackToBack();
        string name;
        int    p;
        int    i;
        name = "testBackToBack";
        for (p = 0; p < pixelNum; p++) begin
            hitBurst(name, p, (4 * p + 3) % binNum, 9, 0); // same word every cycle
            for (i = 0; i < 3; i++) begin
                sendHit(name, p, 8, 1'b1);
                sendHit(name, p, 9, 1'b1);
            end
        end
        runScan(name);
    endtask

    task automatic testSaturation();
        string name;
        name = "testSaturation";
        hitBurst(name, 2, 1, 4, 0);
        hitBurst(name, 2, 6, 300, 0);
        hitBurst(name, 0, 9, 1, 0);
        runScan(name);
    endtask

    task automatic testTieAndRandom();
        string name;
        int    i;
        int    pixel;
        int    bin;
        name = "testTieAndRandom";
        hitBurst(name, 1, 10, 4, 1);
        hitBurst(name, 1, 5, 4, 0);
        hitBurst(name, 3, 15, 2, 0); // tie at both ends of the range
        hitBurst(name, 3, 0, 2, 0);
        runScan(name);
        for (i = 0; i < randomHits; i++) begin
            pixel = takeBits(pixelWidth);
            bin   = takeBits(binWidth);
            hitBurst(name, pixel, bin, 1, takeBits(1));
        end
        runScan(name);
    endtask

    task automatic testFrameIndependence();
        string name;
        int    waited;
        name   = "testFrameIndependence";
        waited = 0;
        hitBurst(name, 0, 12, 5, 0);
        hitBurst(name, 3, 4, 3, 1);
        pulseAcqDone(name);
        // offered through drain and scan, the last one in the final scan cycle
        while (ready !== 1'b1) begin
            if (waited == readyLimit) begin
                abortRun($sformatf("%s: ready did not rise within %0d cycles",
                                   name, readyLimit));
            end
            sendHit(name, 1, 9, 1'b0);
            waited++;
        end
        collectReports(name);
        waitReady(name);
        hitBurst(name, 0, 3, 2, 0); // bin 12 of pixel 0 must be gone
        hitBurst(name, 2, 14, 4, 0);
        runScan(name);
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        res       = 1'b0;
        hitValid  = 1'b0;
        hit       = '0;
        acqDone   = 1'b0;
        errors    = 0;
        lfsrState = lfsrSeed;
        clearModel();
        repeat (resetCycles) @(posedge clk);
        #1;
        res = 1'b1;
        testClearAfterReset();
        testSingleHits();
        testBackToBack();
        testSaturation();
        testTieAndRandom();
        testFrameIndependence();
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
design/sifhParamPkg.sv
design/sifhTypesPkg.sv
design/tdcSampleLatch.sv
design/histControl.sv
design/histRam.sv
design/peakFinder.sv
design/sifhHistTop.sv
verif/sifhHistTb.sv

// File: Makefile
TOOL     = verilator
TOP      = sifhHistTb
FILELIST = src.f
FLAGS    = --binary --timing -j 0
OBJDIR   = obj_dir
PASSMSG  = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the pass line decides the exit status
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
